/* src/adpcm_reg_pkg.sv */
// Register map of the ADPCM gain stage, shared by the register bank and the testbench
package adpcm_reg_pkg;

    // Field widths of the control bytes
    localparam int level_w = 5;
    localparam int pan_w   = 2;
    localparam int atl_w   = 6;

    // Total level lives above the channel addresses
    localparam logic [2:0] addr_total = 3'd7;

    // Channel control byte
    // pan[1] routes to left, pan[0] to right; level 31 is loudest
    typedef struct packed {
        logic [pan_w-1:0]   pan;
        logic               rsv;
        logic [level_w-1:0] level;
    } ch_ctrl_t;

    // Total level byte, 63 is loudest
    typedef struct packed {
        logic [1:0]       rsv;
        logic [atl_w-1:0] atl;
    } total_t;

    // Same write byte, read by address as one view or the other
    typedef union packed {
        ch_ctrl_t ch_ctrl;
        total_t   total;
    } reg_word_u;

endpackage

/* src/adpcm_audio_pkg.sv */
// Sample widths, attenuation table and saturation limits for the gain and mix datapath
package adpcm_audio_pkg;

    // PCM sample width
    localparam int pcm_w = 16;
    // Linear gain, 512 means unity
    localparam int lin_w = 10;
    // Attenuation index, 3 fraction bits and 4 exponent bits
    localparam int db_w  = 7;
    localparam int sh_w  = 4;

    // Output clamp
    localparam logic signed [pcm_w-1:0] pcm_max = 16'sh7fff;
    localparam logic signed [pcm_w-1:0] pcm_min = 16'sh8000;

    // Fraction of the attenuation index to linear gain
    // Roughly 0.75 dB per step, eight steps per halving
    function automatic logic [lin_w-1:0] lin_of(input logic [2:0] frac);
        logic [lin_w-1:0] lin;
        case (frac)
            3'd0: lin = 10'd512;
            3'd1: lin = 10'd470;
            3'd2: lin = 10'd431;
            3'd3: lin = 10'd395;
            3'd4: lin = 10'd362;
            3'd5: lin = 10'd332;
            3'd6: lin = 10'd305;
            default: lin = 10'd280;
        endcase
        return lin;
    endfunction

endpackage

/* src/adpcm_reg_bank.sv */
// Register bank of the ADPCM gain stage, turns write strobes into per-channel pan/level and total level
`timescale 1ns/1ps

module adpcm_reg_bank #(
    parameter int num_ch = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Write port, independent of cen
    input  logic                  wr,
    input  logic [2:0]            wr_addr,
    input  logic [7:0]            wr_data,
    // Flattened per-channel fields, channel 0 in the low bits
    output logic [num_ch*5-1:0]   ch_level,
    output logic [num_ch*2-1:0]   ch_pan,
    // Shared total level
    output logic [5:0]            atl
);

    // Write byte seen through both views
    adpcm_reg_pkg::reg_word_u word;

    assign word = wr_data;

    // One control register per channel
    for (genvar k = 0; k < num_ch; k++) begin : g_ch
        adpcm_reg_pkg::ch_ctrl_t ctrl_q;

        // Zero level and no pan after reset, i.e. silent
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ctrl_q <= '0;
            end else if (wr && wr_addr == 3'(k)) begin
                ctrl_q <= word.ch_ctrl;
            end
        end

        assign ch_level[k*adpcm_reg_pkg::level_w +: adpcm_reg_pkg::level_w] = ctrl_q.level;
        assign ch_pan[k*adpcm_reg_pkg::pan_w +: adpcm_reg_pkg::pan_w]       = ctrl_q.pan;
    end

    // Total level register
    // Addresses between num_ch and 7 hit nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            atl <= '0;
        end else if (wr && wr_addr == adpcm_reg_pkg::addr_total) begin
            atl <= word.total.atl;
        end
    end

endmodule

/* src/adpcm_gain.sv */
// Per-channel gain unit, two cen-stage pipeline applying level, total level and pan to one sample
`timescale 1ns/1ps

module adpcm_gain (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cen,
    input  logic signed [adpcm_audio_pkg::pcm_w-1:0] pcm_in,
    // Current channel control and total level
    input  logic [4:0]                              level,
    input  logic [1:0]                              pan,
    input  logic [5:0]                              atl,
    // Attenuated sample and the pan it entered with
    output logic signed [adpcm_audio_pkg::pcm_w-1:0] pcm_att,
    output logic [1:0]                              pan_out
);

    localparam int pcm_w    = adpcm_audio_pkg::pcm_w;
    localparam int lin_w    = adpcm_audio_pkg::lin_w;
    localparam int db_w     = adpcm_audio_pkg::db_w;
    localparam int sh_w     = adpcm_audio_pkg::sh_w;
    // Unity gain is 1 << lin_frac
    localparam int lin_frac = lin_w - 1;
    // Signed sample times gain with sign bit for the gain
    localparam int prod_w   = pcm_w + lin_w + 1;

    // Inverted sum, 0 means no attenuation
    logic [db_w-1:0] db;
    logic [sh_w-1:0] sh_nxt;

    // Stage 1 registers
    logic signed [pcm_w-1:0] pcm_s1;
    logic [lin_w-1:0]        lin_s1;
    logic [sh_w-1:0]         sh_s1;
    logic [1:0]              pan_s1;

    // Stage 2 datapath
    logic signed [prod_w-1:0] prod;
    logic signed [prod_w-1:0] scaled;

    assign db     = {2'b00, ~level} + {1'b0, ~atl};
    // Upper bits count halvings
    assign sh_nxt = db[db_w-1:3];

    // Stage 1, capture sample and convert dB to linear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_s1 <= '0;
            lin_s1 <= '0;
            sh_s1  <= '0;
            pan_s1 <= '0;
        end else if (cen) begin
            pcm_s1 <= pcm_in;
            // Eight or more halvings mutes the channel
            lin_s1 <= sh_nxt[sh_w-1] ? '0 : adpcm_audio_pkg::lin_of(db[2:0]);
            sh_s1  <= sh_nxt;
            pan_s1 <= pan;
        end
    end

    // Gain is unsigned, keep it positive in the signed product
    assign prod   = pcm_s1 * $signed({1'b0, lin_s1});
    // Table scale and exponent in one arithmetic shift, rounds toward minus infinity
    assign scaled = prod >>> (lin_frac + int'(sh_s1));

    // Stage 2, multiply and shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_att <= '0;
            pan_out <= '0;
        end else if (cen) begin
            // Gain never exceeds unity so the low bits hold the result
            pcm_att <= scaled[pcm_w-1:0];
            pan_out <= pan_s1;
        end
    end

endmodule

/* src/adpcm_mixer.sv */
// Output mixer, sums attenuated channels per pan bit into saturated left and right samples
`timescale 1ns/1ps

module adpcm_mixer #(
    parameter int num_ch = 6
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cen,
    // Flattened channel samples and pans, channel 0 in the low bits
    input  logic [num_ch*adpcm_audio_pkg::pcm_w-1:0] pcm_att,
    input  logic [num_ch*2-1:0]                     pan,
    output logic signed [adpcm_audio_pkg::pcm_w-1:0] left,
    output logic signed [adpcm_audio_pkg::pcm_w-1:0] right
);

    localparam int pcm_w = adpcm_audio_pkg::pcm_w;
    // Three guard bits hold up to seven full-scale channels
    localparam int sum_w = pcm_w + 3;

    logic signed [sum_w-1:0] sum_l;
    logic signed [sum_w-1:0] sum_r;

    // Clamp a wide sum to the sample range
    function automatic logic signed [pcm_w-1:0] sat(input logic signed [sum_w-1:0] s);
        logic signed [pcm_w-1:0] r;
        if (s > adpcm_audio_pkg::pcm_max) begin
            r = adpcm_audio_pkg::pcm_max;
        end else if (s < adpcm_audio_pkg::pcm_min) begin
            r = adpcm_audio_pkg::pcm_min;
        end else begin
            r = s[pcm_w-1:0];
        end
        return r;
    endfunction

    // Pan-gated accumulation
    always_comb begin
        logic signed [pcm_w-1:0] smp;
        sum_l = '0;
        sum_r = '0;
        for (int k = 0; k < num_ch; k++) begin
            smp = pcm_att[k*pcm_w +: pcm_w];
            // Bit 1 left, bit 0 right
            if (pan[2*k+1]) begin
                sum_l = sum_l + smp;
            end
            if (pan[2*k]) begin
                sum_r = sum_r + smp;
            end
        end
    end

    // Output registers, third cen stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else if (cen) begin
            left  <= sat(sum_l);
            right <= sat(sum_r);
        end
    end

endmodule

/* src/adpcm_gain_top.sv */
// Top of the ADPCM gain and mix stage, register bank feeding parallel gain units and the mixer
`timescale 1ns/1ps

module adpcm_gain_top #(
    parameter int num_ch = 6
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cen,
    // Register writes
    input  logic                                    wr,
    input  logic [2:0]                              wr_addr,
    input  logic [7:0]                              wr_data,
    // Decoded PCM, channel 0 in the low bits
    input  logic [num_ch*adpcm_audio_pkg::pcm_w-1:0] pcm_in,
    output logic signed [adpcm_audio_pkg::pcm_w-1:0] left,
    output logic signed [adpcm_audio_pkg::pcm_w-1:0] right
);

    localparam int pcm_w   = adpcm_audio_pkg::pcm_w;
    localparam int level_w = adpcm_reg_pkg::level_w;
    localparam int pan_w   = adpcm_reg_pkg::pan_w;

    // Register bank outputs
    logic [num_ch*level_w-1:0] ch_level;
    logic [num_ch*pan_w-1:0]   ch_pan;
    logic [5:0]                atl;

    // Gain unit outputs toward the mixer
    logic [num_ch*pcm_w-1:0]   pcm_att;
    logic [num_ch*pan_w-1:0]   pan_out;

    adpcm_reg_bank #(
        .num_ch   (num_ch)
    ) i_reg_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ch_level (ch_level),
        .ch_pan   (ch_pan),
        .atl      (atl)
    );

    // One gain unit per channel
    for (genvar k = 0; k < num_ch; k++) begin : g_gain
        adpcm_gain i_gain (
            .clk     (clk),
            .rst_n   (rst_n),
            .cen     (cen),
            .pcm_in  (pcm_in[k*pcm_w +: pcm_w]),
            .level   (ch_level[k*level_w +: level_w]),
            .pan     (ch_pan[k*pan_w +: pan_w]),
            .atl     (atl),
            .pcm_att (pcm_att[k*pcm_w +: pcm_w]),
            .pan_out (pan_out[k*pan_w +: pan_w])
        );
    end

    adpcm_mixer #(
        .num_ch  (num_ch)
    ) i_mixer (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .pcm_att (pcm_att),
        .pan     (pan_out),
        .left    (left),
        .right   (right)
    );

endmodule

/* bench/adpcm_gain_props.sv */
// Concurrent output checks of the gain stage that bind attaches to its top level
`timescale 1ns/1ps

module adpcm_gain_props #(
    parameter int num_ch = 6
) (
    input logic                clk,
    input logic                rst_n,
    input logic                cen,
    input logic [num_ch*2-1:0] ch_pan,
    input logic signed [15:0]  left,
    input logic signed [15:0]  right
);

    // All-pans-zero flag following the sample through the two gain stages
    logic zero_s1;
    logic zero_s2;

    // Number of assertion failures so far
    int err_cnt = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_s1 <= 1'b0;
            zero_s2 <= 1'b0;
        end else if (cen) begin
            zero_s1 <= (ch_pan == '0);
            zero_s2 <= zero_s1;
        end
    end

    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        !cen |=> $stable(left) && $stable(right))
        else begin
            $error("left or right changed on a clock without cen");
            err_cnt++;
        end

    reset_a: assert property (@(posedge clk) !rst_n |-> left == '0 && right == '0)
        else begin
            $error("left or right not zero during reset");
            err_cnt++;
        end

    // Third cen stage of a sample that entered with no pan
    unpanned_a: assert property (@(posedge clk) disable iff (!rst_n)
        cen && zero_s2 |=> left == '0 && right == '0)
        else begin
            $error("output not zero for a sample that entered with all pans off");
            err_cnt++;
        end

endmodule

bind adpcm_gain_top adpcm_gain_props #(.num_ch(num_ch)) i_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .cen    (cen),
    .ch_pan (ch_pan),
    .left   (left),
    .right  (right)
);

/* bench/adpcm_gain_tb.sv */
// Top-level testbench of the ADPCM gain stage that checks random stimulus against a model
`timescale 1ns/1ps

module adpcm_gain_tb;

    localparam int num_ch     = 6;
    localparam int num_tests  = 6;
    localparam int samples    = 200;
    // Twice the nominal run of three 100 ns clocks per sample
    localparam int timeout_ns = 2 * num_tests * samples * 3 * 100;

    logic                 clk;
    logic                 rst_n;
    logic                 cen;
    logic                 wr;
    logic [2:0]           wr_addr;
    logic [7:0]           wr_data;
    logic [num_ch*16-1:0] pcm_in;
    logic signed [15:0]   left;
    logic signed [15:0]   right;

    // Model copy of the register bank
    logic [4:0] mdl_level [num_ch] = '{default: '0};
    logic [1:0] mdl_pan [num_ch]   = '{default: '0};
    logic [5:0] mdl_atl = '0;
    int lin_table [8] = '{512, 470, 431, 395, 362, 332, 305, 280};
    // Expected outputs of samples still in the pipeline
    logic signed [15:0] exp_l_q [$];
    logic signed [15:0] exp_r_q [$];

    int seed     = 19252;
    int err_cnt  = 0;
    int chk_cnt  = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    adpcm_gain_top #(
        .num_ch  (num_ch)
    ) i_adpcm_gain_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .wr      (wr),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .pcm_in  (pcm_in),
        .left    (left),
        .right   (right)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog: the run timed out at %0t before all tests finished", $time);
        $display("Something failed");
        $finish;
    end

    // Index d = (31 - L) + (63 - A) with table entry d mod 8 and shift 9 + d div 8
    function automatic int gain_model(input int pcm, input int level, input int atl_v);
        int d;
        int p;
        d = (31 - level) + (63 - atl_v);
        if (d / 8 >= 8) begin
            return 0;
        end
        p = pcm * lin_table[d % 8];
        return p >>> (9 + d / 8);
    endfunction

    function automatic logic signed [15:0] clamp16(input int s);
        if (s > 32767) begin
            return 16'sh7fff;
        end else if (s < -32768) begin
            return 16'sh8000;
        end
        return 16'(s);
    endfunction

    function automatic logic [7:0] ch_byte(input logic [1:0] pan, input logic [4:0] level);
        adpcm_reg_pkg::reg_word_u w;
        w.ch_ctrl.pan   = pan;
        w.ch_ctrl.rsv   = 1'b0;
        w.ch_ctrl.level = level;
        return w;
    endfunction

    // One clock with the strobe high while cen stays low
    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        adpcm_reg_pkg::reg_word_u w;
        w       = data;
        wr      = 1'b1;
        wr_addr = addr;
        wr_data = data;
        if (addr < num_ch) begin
            mdl_level[addr] = w.ch_ctrl.level;
            mdl_pan[addr]   = w.ch_ctrl.pan;
        end else if (addr == adpcm_reg_pkg::addr_total) begin
            mdl_atl = w.total.atl;
        end
        @(negedge clk);
        wr = 1'b0;
    endtask

    // Three clocks with cen high in the first
    task automatic step_sample(input bit full_scale);
        int sum_l;
        int sum_r;
        int att;
        logic [15:0] fs;
        logic signed [15:0] exp_l;
        logic signed [15:0] exp_r;
        sum_l = 0;
        sum_r = 0;
        cen   = 1'b1;
        fs    = ($random(seed) & 1) != 0 ? 16'h7fff : 16'h8000;
        for (int k = 0; k < num_ch; k++) begin
            pcm_in[k*16 +: 16] = full_scale ? fs : 16'($random(seed));
        end
        for (int k = 0; k < num_ch; k++) begin
            att = gain_model($signed(pcm_in[k*16 +: 16]), mdl_level[k], mdl_atl);
            if (mdl_pan[k][1]) begin
                sum_l += att;
            end
            if (mdl_pan[k][0]) begin
                sum_r += att;
            end
        end
        exp_l_q.push_back(clamp16(sum_l));
        exp_r_q.push_back(clamp16(sum_r));
        @(negedge clk);
        cen = 1'b0;
        // Outputs now carry the sample of two cen edges back
        exp_l = exp_l_q.pop_front();
        exp_r = exp_r_q.pop_front();
        chk_cnt++;
        if (left !== exp_l) begin
            $display("** Error at %0t: left expected %0d, got %0d", $time, exp_l, left);
            err_cnt++;
        end
        if (right !== exp_r) begin
            $display("** Error at %0t: right expected %0d, got %0d", $time, exp_r, right);
            err_cnt++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("Test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        int e0;
        int c;
        int assert_errs;
        rst_n   = 1'b0;
        cen     = 1'b0;
        wr      = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        pcm_in  = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // Reset zeros fill the first two outputs
        repeat (2) begin
            exp_l_q.push_back('0);
            exp_r_q.push_back('0);
        end

        // All channels muted and unpanned
        e0 = err_cnt;
        repeat (samples) step_sample(1'b0);
        end_test("after reset", e0);

        e0 = err_cnt;
        write_reg(3'd0, ch_byte(2'b11, 5'd31));
        write_reg(adpcm_reg_pkg::addr_total, 8'd63);
        repeat (samples) step_sample(1'b0);
        end_test("unity pass-through", e0);

        // One panned channel per group where random levels reach the muted range
        e0 = err_cnt;
        for (int g = 0; g < samples / 10; g++) begin
            c = $unsigned($random(seed)) % num_ch;
            for (int k = 0; k < num_ch; k++) begin
                write_reg(3'(k), ch_byte(k == c ? 2'(1 + $unsigned($random(seed)) % 3) : 2'b00,
                                         5'($random(seed))));
            end
            write_reg(adpcm_reg_pkg::addr_total, {2'b00, 6'($random(seed))});
            repeat (10) step_sample(1'b0);
        end
        end_test("random attenuation", e0);

        // First group leaves every channel unpanned at unity gain
        e0 = err_cnt;
        write_reg(adpcm_reg_pkg::addr_total, 8'd63);
        for (int g = 0; g < samples / 10; g++) begin
            for (int k = 0; k < num_ch; k++) begin
                write_reg(3'(k), ch_byte(g == 0 ? 2'b00 : 2'($random(seed)), 5'd31));
            end
            repeat (10) step_sample(1'b0);
        end
        end_test("pan routing", e0);

        e0 = err_cnt;
        for (int k = 0; k < num_ch; k++) begin
            write_reg(3'(k), ch_byte(2'b11, 5'd31));
        end
        repeat (samples) step_sample(1'b1);
        end_test("saturation", e0);

        // Upper levels keep the shift small while atl changes between samples in flight
        e0 = err_cnt;
        for (int k = 0; k < num_ch; k++) begin
            write_reg(3'(k), ch_byte(2'($random(seed)), 5'd24 | 5'($random(seed) & 7)));
        end
        for (int g = 0; g < samples / 10; g++) begin
            write_reg(adpcm_reg_pkg::addr_total, {2'b00, 6'd48 | 6'($random(seed) & 15)});
            // Unmapped address right after the total level must leave every register alone
            write_reg(3'd6, 8'($random(seed)));
            repeat (10) step_sample(1'b0);
        end
        end_test("write decoding", e0);

        assert_errs = i_adpcm_gain_top.i_props.err_cnt;
        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors, %0d assertion failures",
                 pass_cnt, fail_cnt, chk_cnt, err_cnt, assert_errs);
        if (err_cnt == 0 && fail_cnt == 0 && assert_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
src/adpcm_reg_pkg.sv
src/adpcm_audio_pkg.sv
src/adpcm_reg_bank.sv
src/adpcm_gain.sv
src/adpcm_mixer.sv
src/adpcm_gain_top.sv
bench/adpcm_gain_props.sv
bench/adpcm_gain_tb.sv

/* Makefile */
VERILATOR       ?= verilator
TOP             ?= adpcm_gain_tb
FILELIST        ?= files.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG        ?= Something failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
